//--- run_sim.sh
#!/bin/sh
# Build and run the spectrum post-processing testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_spec_post -Mdir "$BUILD_DIR" -f vlog.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed, see $BUILD_LOG"
  exit 1
fi

"./$BUILD_DIR/Vtb_spec_post" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Verification passed" "$SIM_LOG"; then
  exit 0
fi

echo "Pass line not found in $SIM_LOG"
exit 1

//--- src/axis_pipe_reg.sv
/* Single-entry valid/ready register slice for any packed payload type.
   Loads when empty or when the held beat leaves on the same cycle */
`timescale 1ns/1ns

module axis_pipe_reg #(
  parameter type PAYLOAD_T = logic
) (
  input  logic     ce_clk,
  input  logic     i_rst_n,
  input  logic     i_valid,
  input  PAYLOAD_T i_data,
  output logic     o_ready,
  input  logic     i_ready,
  output logic     o_valid,
  output PAYLOAD_T o_data
);

  logic     valid_q;
  PAYLOAD_T data_q;

  assign o_ready = !valid_q || i_ready;

  always_ff @(posedge ce_clk) begin
    if (!i_rst_n) begin
      valid_q <= 1'b0;
    end else if (o_ready) begin
      valid_q <= i_valid;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (o_ready && i_valid) begin
      data_q <= i_data;
    end
  end

  assign o_valid = valid_q;
  assign o_data  = data_q;

endmodule

//--- src/bin_reorder.sv
/* Frame buffer for one FFT frame. Bins are written at their index, then the
   whole frame is read out in centered, natural or reversed order */
`timescale 1ns/1ns

module bin_reorder (
  input  logic                            ce_clk,
  input  logic                            i_rst_n,
  input  logic                            i_clear,
  input  logic [spec_pkg::SIZE_W-1:0]     i_size_log2,
  input  spec_pkg::shift_mode_t           i_shift_mode,
  input  logic [spec_pkg::CPLX_W-1:0]     i_tdata,
  input  logic [spec_pkg::BIN_W-1:0]      i_tuser,
  input  logic                            i_tlast,
  input  logic                            i_tvalid,
  output logic                            o_tready,
  output logic [spec_pkg::CPLX_W-1:0]     o_tdata,
  output logic                            o_tlast,
  output logic                            o_tvalid,
  input  logic                            i_o_tready
);

  import spec_pkg::*;

  typedef enum logic {
    ST_FILL,
    ST_DRAIN
  } state_t;

  state_t            state;
  logic              first_q;
  logic [SIZE_W-1:0] size_q;
  shift_mode_t       mode_q;
  logic [BIN_W:0]    rd_cnt;
  logic [BIN_W:0]    frame_len;
  logic [BIN_W-1:0]  bin_mask;
  logic [BIN_W-1:0]  half_len;
  logic [BIN_W-1:0]  rd_addr;
  logic              in_fire;
  logic              out_fire;
  logic              rd_issue;
  logic [CPLX_W-1:0] mem [2**MAX_FFT_SIZE_LOG2];
  logic [CPLX_W-1:0] out_data_q;
  logic              out_last_q;
  logic              out_valid_q;

  assign o_tready = (state == ST_FILL);
  assign in_fire  = i_tvalid && o_tready;
  assign out_fire = out_valid_q && i_o_tready;

  assign frame_len = (BIN_W+1)'(1) << size_q;
  assign bin_mask  = frame_len[BIN_W-1:0] - 1'b1;
  assign half_len  = frame_len[BIN_W:1];

  // Next read goes out when the prefetch slot is free or draining
  assign rd_issue = (state == ST_DRAIN) && (rd_cnt < frame_len) &&
                    (!out_valid_q || i_o_tready);

  ////////////////////////////////
  // Read address mapping
  ////////////////////////////////
  always_comb begin
    case (mode_q)
      SHIFT_CENTER:  rd_addr = (rd_cnt[BIN_W-1:0] + half_len) & bin_mask;
      SHIFT_REVERSE: rd_addr = bin_mask - rd_cnt[BIN_W-1:0];
      default:       rd_addr = rd_cnt[BIN_W-1:0];
    endcase
  end

  always_ff @(posedge ce_clk) begin
    if (in_fire) begin
      mem[i_tuser] <= i_tdata;
    end
  end

  // Prefetch register in front of the output port
  always_ff @(posedge ce_clk) begin
    if (rd_issue) begin
      out_data_q <= mem[rd_addr];
      out_last_q <= (rd_cnt == frame_len - 1'b1);
    end
  end

  ////////////////////////////////
  // Fill / drain control
  ////////////////////////////////
  always_ff @(posedge ce_clk) begin
    if (!i_rst_n || i_clear) begin
      state       <= ST_FILL;
      first_q     <= 1'b1;
      size_q      <= DEFAULT_FFT_SIZE_LOG2;
      mode_q      <= SHIFT_CENTER;
      rd_cnt      <= '0;
      out_valid_q <= 1'b0;
    end else begin
      if (in_fire) begin
        first_q <= 1'b0;
        // Frame settings are frozen at its first bin
        if (first_q) begin
          size_q <= i_size_log2;
          mode_q <= i_shift_mode;
        end
        if (i_tlast) begin
          state  <= ST_DRAIN;
          rd_cnt <= '0;
        end
      end

      if (rd_issue) begin
        rd_cnt <= rd_cnt + 1'b1;
      end

      if (rd_issue) begin
        out_valid_q <= 1'b1;
      end else if (i_o_tready) begin
        out_valid_q <= 1'b0;
      end

      if (out_fire && out_last_q) begin
        state   <= ST_FILL;
        first_q <= 1'b1;
      end
    end
  end

  assign o_tdata  = out_data_q;
  assign o_tlast  = out_last_q;
  assign o_tvalid = out_valid_q;

endmodule

//--- src/power_path.sv
/* Output stage. Complex bins pass through one register slice; in power mode
   I*I+Q*Q is registered first, then rounded, clipped and placed in the upper half */
`timescale 1ns/1ns

module power_path (
  input  logic                            ce_clk,
  input  logic                            i_rst_n,
  input  logic                            i_clear,
  input  spec_pkg::out_mode_t             i_out_mode,
  input  logic [spec_pkg::CPLX_W-1:0]     i_tdata,
  input  logic                            i_tlast,
  input  logic                            i_tvalid,
  output logic                            o_tready,
  output logic [spec_pkg::CPLX_W-1:0]     o_tdata,
  output logic                            o_tlast,
  output logic                            o_tvalid,
  input  logic                            i_o_tready
);

  import spec_pkg::*;

  logic                          pipe_rst_n;
  logic                          is_pow;
  logic signed [SAMPLE_W-1:0]    in_i;
  logic signed [SAMPLE_W-1:0]    in_q;
  logic signed [2*SAMPLE_W-1:0]  prod_i;
  logic signed [2*SAMPLE_W-1:0]  prod_q;
  magsq_beat_t                   s1_in;
  magsq_beat_t                   s1_out;
  logic                          s1_in_valid;
  logic                          s1_in_ready;
  logic                          s1_out_valid;
  logic                          s1_out_ready;
  cplx_beat_t                    s2_in;
  cplx_beat_t                    s2_out;
  logic                          s2_in_valid;
  logic                          s2_in_ready;
  logic [MAGSQ_W-1:0]            rounded;
  logic [SAMPLE_W-1:0]           power;

  assign pipe_rst_n = i_rst_n && !i_clear;
  assign is_pow     = (i_out_mode == OUT_MAG_SQ);

  ////////////////////////////////
  // Stage 1 magnitude squared
  ////////////////////////////////
  assign in_i   = i_tdata[CPLX_W-1:SAMPLE_W];
  assign in_q   = i_tdata[SAMPLE_W-1:0];
  assign prod_i = in_i * in_i;
  assign prod_q = in_q * in_q;

  assign s1_in.magsq = MAGSQ_W'($unsigned(prod_i)) + MAGSQ_W'($unsigned(prod_q));
  assign s1_in.last  = i_tlast;
  assign s1_in_valid = i_tvalid && is_pow;

  axis_pipe_reg #(.PAYLOAD_T(magsq_beat_t)) u_magsq_reg (
    .ce_clk  (ce_clk),
    .i_rst_n (pipe_rst_n),
    .i_valid (s1_in_valid),
    .i_data  (s1_in),
    .o_ready (s1_in_ready),
    .i_ready (s1_out_ready),
    .o_valid (s1_out_valid),
    .o_data  (s1_out)
  );

  // Round half up at bit 15, then saturate to the positive 16-bit range
  assign rounded = (s1_out.magsq + (MAGSQ_W'(1) << (SAMPLE_W-1))) >> SAMPLE_W;
  assign power   = (rounded > MAGSQ_W'(2**(SAMPLE_W-1) - 1)) ?
                   {1'b0, {(SAMPLE_W-1){1'b1}}} : rounded[SAMPLE_W-1:0];

  ////////////////////////////////
  // Stage 2 output word
  ////////////////////////////////
  // Complex beats wait until no power beat is ahead of them in stage 1
  assign s1_out_ready = s2_in_ready;
  assign s2_in_valid  = s1_out_valid || (i_tvalid && !is_pow);
  assign s2_in.data   = s1_out_valid ? {power, {SAMPLE_W{1'b0}}} : i_tdata;
  assign s2_in.last   = s1_out_valid ? s1_out.last : i_tlast;

  assign o_tready = is_pow ? s1_in_ready : (s2_in_ready && !s1_out_valid);

  axis_pipe_reg #(.PAYLOAD_T(cplx_beat_t)) u_out_reg (
    .ce_clk  (ce_clk),
    .i_rst_n (pipe_rst_n),
    .i_valid (s2_in_valid),
    .i_data  (s2_in),
    .o_ready (s2_in_ready),
    .i_ready (i_o_tready),
    .o_valid (o_tvalid),
    .o_data  (s2_out)
  );

  assign o_tdata = s2_out.data;
  assign o_tlast = s2_out.last;

endmodule

//--- src/spec_pkg.sv
/* Common definitions for the spectrum post-processing block. Widths, settings
   bus addresses, readback selects, mode encodings and stream beat payloads */
package spec_pkg;

  // Sample and frame geometry
  localparam int SAMPLE_W          = 16;
  localparam int CPLX_W            = 32;
  localparam int MAX_FFT_SIZE_LOG2 = 8;
  localparam int MIN_FFT_SIZE_LOG2 = 3;
  localparam int SIZE_W            = 4;
  localparam int BIN_W             = 8;
  localparam int MAGSQ_W           = 33;

  // Settings bus
  localparam int SET_ADDR_W = 8;
  localparam int SET_DATA_W = 32;
  localparam int RB_SEL_W   = 3;

  localparam logic [SET_ADDR_W-1:0] SR_FFT_RESET        = SET_ADDR_W'(129);
  localparam logic [SET_ADDR_W-1:0] SR_FFT_SIZE_LOG2    = SET_ADDR_W'(130);
  localparam logic [SET_ADDR_W-1:0] SR_FFT_SHIFT_CONFIG = SET_ADDR_W'(133);
  localparam logic [SET_ADDR_W-1:0] SR_OUT_MODE         = SET_ADDR_W'(134);
  localparam logic [SET_ADDR_W-1:0] SR_READBACK         = SET_ADDR_W'(255);

  localparam logic [RB_SEL_W-1:0] RB_FFT_RESET        = RB_SEL_W'(0);
  localparam logic [RB_SEL_W-1:0] RB_FFT_SIZE_LOG2    = RB_SEL_W'(1);
  localparam logic [RB_SEL_W-1:0] RB_FFT_SHIFT_CONFIG = RB_SEL_W'(2);
  localparam logic [RB_SEL_W-1:0] RB_OUT_MODE         = RB_SEL_W'(3);
  localparam logic [SET_DATA_W-1:0] RB_BAD_ADDR       = 32'h0BAD_C0DE;

  localparam logic [SIZE_W-1:0] DEFAULT_FFT_SIZE_LOG2 = SIZE_W'(8);

  // Value 3 is treated as natural order
  typedef enum logic [1:0] {
    SHIFT_CENTER  = 2'd0,
    SHIFT_NATURAL = 2'd1,
    SHIFT_REVERSE = 2'd2
  } shift_mode_t;

  // Values 1 and 3 are treated as complex output
  typedef enum logic [1:0] {
    OUT_COMPLEX = 2'd0,
    OUT_MAG_SQ  = 2'd2
  } out_mode_t;

  typedef struct packed {
    logic [CPLX_W-1:0] data;
    logic              last;
  } cplx_beat_t;

  typedef struct packed {
    logic [MAGSQ_W-1:0] magsq;
    logic               last;
  } magsq_beat_t;

endpackage

//--- src/spec_post_top.sv
/* Spectrum post-processing top. Settings bank steering the bin reorder buffer,
   which feeds the complex or power output stage */
`timescale 1ns/1ns

module spec_post_top (
  input  logic                                ce_clk,
  input  logic                                i_rst_n,
  input  logic                                i_set_stb,
  input  logic [spec_pkg::SET_ADDR_W-1:0]     i_set_addr,
  input  logic [spec_pkg::SET_DATA_W-1:0]     i_set_data,
  output logic [spec_pkg::SET_DATA_W-1:0]     o_rb_data,
  input  logic [spec_pkg::CPLX_W-1:0]         i_tdata,
  input  logic [spec_pkg::BIN_W-1:0]          i_tuser,
  input  logic                                i_tlast,
  input  logic                                i_tvalid,
  output logic                                o_tready,
  output logic [spec_pkg::CPLX_W-1:0]         o_tdata,
  output logic                                o_tlast,
  output logic                                o_tvalid,
  input  logic                                i_tready
);

  import spec_pkg::*;

  logic              fft_reset;
  logic [SIZE_W-1:0] size_log2;
  shift_mode_t       shift_mode;
  out_mode_t         out_mode;

  // Reordered stream into the output stage
  logic [CPLX_W-1:0] ro_tdata;
  logic              ro_tlast;
  logic              ro_tvalid;
  logic              ro_tready;

  spec_settings u_settings (
    .ce_clk       (ce_clk),
    .i_rst_n      (i_rst_n),
    .i_set_stb    (i_set_stb),
    .i_set_addr   (i_set_addr),
    .i_set_data   (i_set_data),
    .o_fft_reset  (fft_reset),
    .o_size_log2  (size_log2),
    .o_shift_mode (shift_mode),
    .o_out_mode   (out_mode),
    .o_rb_data    (o_rb_data)
  );

  bin_reorder u_reorder (
    .ce_clk       (ce_clk),
    .i_rst_n      (i_rst_n),
    .i_clear      (fft_reset),
    .i_size_log2  (size_log2),
    .i_shift_mode (shift_mode),
    .i_tdata      (i_tdata),
    .i_tuser      (i_tuser),
    .i_tlast      (i_tlast),
    .i_tvalid     (i_tvalid),
    .o_tready     (o_tready),
    .o_tdata      (ro_tdata),
    .o_tlast      (ro_tlast),
    .o_tvalid     (ro_tvalid),
    .i_o_tready   (ro_tready)
  );

  power_path u_power (
    .ce_clk     (ce_clk),
    .i_rst_n    (i_rst_n),
    .i_clear    (fft_reset),
    .i_out_mode (out_mode),
    .i_tdata    (ro_tdata),
    .i_tlast    (ro_tlast),
    .i_tvalid   (ro_tvalid),
    .o_tready   (ro_tready),
    .o_tdata    (o_tdata),
    .o_tlast    (o_tlast),
    .o_tvalid   (o_tvalid),
    .i_o_tready (i_tready)
  );

endmodule

//--- src/spec_settings.sv
/* Register bank on the strobed settings bus. Holds the block reset, frame size,
   shift order and output mode, and returns one of them on the readback word */
`timescale 1ns/1ns

module spec_settings (
  input  logic                                ce_clk,
  input  logic                                i_rst_n,
  input  logic                                i_set_stb,
  input  logic [spec_pkg::SET_ADDR_W-1:0]     i_set_addr,
  input  logic [spec_pkg::SET_DATA_W-1:0]     i_set_data,
  output logic                                o_fft_reset,
  output logic [spec_pkg::SIZE_W-1:0]         o_size_log2,
  output spec_pkg::shift_mode_t               o_shift_mode,
  output spec_pkg::out_mode_t                 o_out_mode,
  output logic [spec_pkg::SET_DATA_W-1:0]     o_rb_data
);

  import spec_pkg::*;

  logic                fft_reset_q;
  logic [SIZE_W-1:0]   size_q;
  shift_mode_t         shift_q;
  out_mode_t           out_mode_q;
  logic [RB_SEL_W-1:0] rb_sel_q;
  logic [SIZE_W-1:0]   size_wr;

  // Size clamped into the supported range
  always_comb begin
    if (i_set_data < SET_DATA_W'(MIN_FFT_SIZE_LOG2)) begin
      size_wr = SIZE_W'(MIN_FFT_SIZE_LOG2);
    end else if (i_set_data > SET_DATA_W'(MAX_FFT_SIZE_LOG2)) begin
      size_wr = SIZE_W'(MAX_FFT_SIZE_LOG2);
    end else begin
      size_wr = i_set_data[SIZE_W-1:0];
    end
  end

  ////////////////////////////////
  // Register writes
  ////////////////////////////////
  always_ff @(posedge ce_clk) begin
    if (!i_rst_n) begin
      fft_reset_q <= 1'b0;
      size_q      <= DEFAULT_FFT_SIZE_LOG2;
      shift_q     <= SHIFT_CENTER;
      out_mode_q  <= OUT_COMPLEX;
      rb_sel_q    <= RB_FFT_RESET;
    end else if (i_set_stb) begin
      case (i_set_addr)
        SR_FFT_RESET:        fft_reset_q <= i_set_data[0];
        SR_FFT_SIZE_LOG2:    size_q      <= size_wr;
        SR_FFT_SHIFT_CONFIG: shift_q     <= shift_mode_t'(i_set_data[1:0]);
        SR_OUT_MODE:         out_mode_q  <= out_mode_t'(i_set_data[1:0]);
        SR_READBACK:         rb_sel_q    <= i_set_data[RB_SEL_W-1:0];
        default: begin
        end
      endcase
    end
  end

  assign o_fft_reset  = fft_reset_q;
  assign o_size_log2  = size_q;
  assign o_shift_mode = shift_q;
  assign o_out_mode   = out_mode_q;

  ////////////////////////////////
  // Readback mux
  ////////////////////////////////
  always_comb begin
    case (rb_sel_q)
      RB_FFT_RESET:        o_rb_data = SET_DATA_W'(fft_reset_q);
      RB_FFT_SIZE_LOG2:    o_rb_data = SET_DATA_W'(size_q);
      RB_FFT_SHIFT_CONFIG: o_rb_data = SET_DATA_W'(shift_q);
      RB_OUT_MODE:         o_rb_data = SET_DATA_W'(out_mode_q);
      default:             o_rb_data = RB_BAD_ADDR;
    endcase
  end

endmodule

//--- tb/spec_post_asserts.sv
/* Stream protocol checks bound into the spectrum post-processing top.
   Covers output hold under stall, idle output in reset and input hold */
`timescale 1ns/1ns

module spec_post_asserts (
  input logic                          ce_clk,
  input logic                          i_rst_n,
  input logic                          i_fft_reset,
  input logic                          i_in_tvalid,
  input logic                          i_in_tready,
  input logic [spec_pkg::CPLX_W-1:0]   i_in_tdata,
  input logic                          i_out_tvalid,
  input logic                          i_out_tready,
  input logic [spec_pkg::CPLX_W-1:0]   i_out_tdata,
  input logic                          i_out_tlast
);

  // Stalled output beat stays put
  a_out_hold: assert property (@(posedge ce_clk) disable iff (!i_rst_n || i_fft_reset)
    (i_out_tvalid && !i_out_tready) |=>
      (i_out_tvalid && $stable(i_out_tdata) && $stable(i_out_tlast)))
    else $error("output beat changed while stalled");

  a_reset_idle: assert property (@(posedge ce_clk)
    (!i_rst_n || i_fft_reset) |=> !i_out_tvalid)
    else $error("output valid during reset");

  // A beat offered while not ready is still there next cycle
  a_in_hold: assert property (@(posedge ce_clk) disable iff (!i_rst_n || i_fft_reset)
    (i_in_tvalid && !i_in_tready) |=> (i_in_tvalid && $stable(i_in_tdata)))
    else $error("input beat dropped while not ready");

endmodule

bind spec_post_top spec_post_asserts u_asserts (
  .ce_clk       (ce_clk),
  .i_rst_n      (i_rst_n),
  .i_fft_reset  (fft_reset),
  .i_in_tvalid  (i_tvalid),
  .i_in_tready  (o_tready),
  .i_in_tdata   (i_tdata),
  .i_out_tvalid (o_tvalid),
  .i_out_tready (i_tready),
  .i_out_tdata  (o_tdata),
  .i_out_tlast  (o_tlast)
);

//--- tb/tb_spec_post.sv
/* Directed testbench for the spectrum post-processing top. Runs register,
   reorder, back-pressure, power and mid-frame reset tests, then reports */
`timescale 1ns/1ns

module tb_spec_post;

  import spec_pkg::*;

  localparam int TIMEOUT_CYC = 2000;

  logic                  ce_clk;
  logic                  i_rst_n;
  logic                  i_set_stb;
  logic [SET_ADDR_W-1:0] i_set_addr;
  logic [SET_DATA_W-1:0] i_set_data;
  logic [SET_DATA_W-1:0] o_rb_data;
  logic [CPLX_W-1:0]     i_tdata;
  logic [BIN_W-1:0]      i_tuser;
  logic                  i_tlast;
  logic                  i_tvalid;
  logic                  o_tready;
  logic [CPLX_W-1:0]     o_tdata;
  logic                  o_tlast;
  logic                  o_tvalid;
  logic                  i_tready;

  integer            seed;
  int                word_errs;
  int                rb_errs;
  int                last_errs;
  int                flag_errs;
  int                other_errs;
  logic [CPLX_W-1:0] frame_in [2**MAX_FFT_SIZE_LOG2];
  logic [CPLX_W-1:0] exp_q [$];

  spec_post_top DUT (.*);

  initial begin
    ce_clk = 1'b0;
    forever #2 ce_clk = ~ce_clk;
  end

  //////////////////////////////
  // Compare tasks
  //////////////////////////////
  task automatic check_word(input logic [CPLX_W-1:0] got, input logic [CPLX_W-1:0] exp,
                            input int idx);
    if (got !== exp) begin
      word_errs++;
      $display("[ERROR] %0t: beat %0d data %h, expected %h", $time, idx, got, exp);
    end
  endtask

  task automatic check_rb(input logic [SET_DATA_W-1:0] got, input logic [SET_DATA_W-1:0] exp,
                          input int sel);
    if (got !== exp) begin
      rb_errs++;
      $display("[ERROR] %0t: readback %0d is %h, expected %h", $time, sel, got, exp);
    end
  endtask

  task automatic check_last(input logic got, input logic exp, input int idx);
    if (got !== exp) begin
      last_errs++;
      $display("[ERROR] %0t: beat %0d last %b, expected %b", $time, idx, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      flag_errs++;
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  //////////////////////////////
  // Bus and stream drivers
  //////////////////////////////
  task automatic set_write(input logic [SET_ADDR_W-1:0] addr,
                           input logic [SET_DATA_W-1:0] data);
    i_set_stb  = 1'b1;
    i_set_addr = addr;
    i_set_data = data;
    @(negedge ce_clk);
    i_set_stb  = 1'b0;
  endtask

  task automatic read_reg(input logic [RB_SEL_W-1:0] sel, input logic [SET_DATA_W-1:0] exp);
    set_write(SR_READBACK, SET_DATA_W'(sel));
    check_rb(o_rb_data, exp, int'(sel));
  endtask

  task automatic configure(input int size, input shift_mode_t shift, input out_mode_t mode);
    set_write(SR_FFT_SIZE_LOG2, SET_DATA_W'(size));
    set_write(SR_FFT_SHIFT_CONFIG, SET_DATA_W'(shift));
    set_write(SR_OUT_MODE, SET_DATA_W'(mode));
  endtask

  // Bin words carry their index in I and its inverse in Q
  task automatic fill_frame(input int n, input logic [SAMPLE_W-1:0] base);
    for (int k = 0; k < n; k++) begin
      frame_in[k] = {SAMPLE_W'(base + k), SAMPLE_W'(~(base + k))};
    end
  endtask

  task automatic expect_order(input int n, input shift_mode_t shift);
    int addr;
    for (int c = 0; c < n; c++) begin
      case (shift)
        SHIFT_CENTER:  addr = (c + n / 2) % n;
        SHIFT_REVERSE: addr = n - 1 - c;
        default:       addr = c;
      endcase
      exp_q.push_back(frame_in[addr]);
    end
  endtask

  function automatic logic [CPLX_W-1:0] power_word(input logic [CPLX_W-1:0] w);
    longint i_v;
    longint q_v;
    longint p;
    i_v = longint'($signed(w[CPLX_W-1:SAMPLE_W]));
    q_v = longint'($signed(w[SAMPLE_W-1:0]));
    p = (i_v * i_v + q_v * q_v + 32768) >>> 16;
    if (p > 32767) begin
      p = 32767;
    end
    return {SAMPLE_W'(p), {SAMPLE_W{1'b0}}};
  endfunction

  // Sends the first count bins of a shuffled n-bin frame
  task automatic send_bins(input int n, input int count);
    int order [$];
    int j;
    int tmp;
    int wait_cyc;
    for (int k = 0; k < n; k++) begin
      order.push_back(k);
    end
    for (int k = n - 1; k > 0; k--) begin
      j = $unsigned($random(seed)) % (k + 1);
      tmp = order[k];
      order[k] = order[j];
      order[j] = tmp;
    end
    for (int k = 0; k < count; k++) begin
      i_tvalid = 1'b1;
      i_tuser  = BIN_W'(order[k]);
      i_tdata  = frame_in[order[k]];
      i_tlast  = (k == n - 1);
      wait_cyc = 0;
      while (!o_tready && wait_cyc < TIMEOUT_CYC) begin
        @(negedge ce_clk);
        wait_cyc++;
      end
      if (!o_tready) begin
        other_errs++;
        $display("Input stream never became ready for bin %0d", order[k]);
        break;
      end
      @(negedge ce_clk);
    end
    i_tvalid = 1'b0;
    i_tlast  = 1'b0;
  endtask

  task automatic collect_frame(input int n, input bit rand_ready);
    int   got_cnt;
    int   wait_cyc;
    logic rdy;
    got_cnt  = 0;
    wait_cyc = 0;
    while (got_cnt < n && wait_cyc < TIMEOUT_CYC) begin
      rdy = rand_ready ? 1'($random(seed)) : 1'b1;
      i_tready = rdy;
      if (o_tvalid && rdy) begin
        check_word(o_tdata, exp_q.pop_front(), got_cnt);
        check_last(o_tlast, got_cnt == n - 1, got_cnt);
        got_cnt++;
        wait_cyc = 0;
      end else begin
        wait_cyc++;
      end
      @(negedge ce_clk);
    end
    i_tready = 1'b0;
    if (got_cnt < n) begin
      other_errs++;
      $display("Output stream stalled after %0d of %0d beats", got_cnt, n);
    end
    exp_q.delete();
    repeat (4) @(negedge ce_clk);
    check_flag(o_tvalid, 1'b0, "o_tvalid after frame end");
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////
  task automatic test_reset_state();
    check_flag(o_tvalid, 1'b0, "o_tvalid after reset");
    check_flag(o_tready, 1'b1, "o_tready after reset");
    read_reg(RB_FFT_RESET, 0);
    read_reg(RB_FFT_SIZE_LOG2, 8);
    read_reg(RB_FFT_SHIFT_CONFIG, 0);
    read_reg(RB_OUT_MODE, 0);
    read_reg(3'd5, RB_BAD_ADDR);
  endtask

  task automatic test_reg_writes();
    set_write(SR_FFT_RESET, 1);
    read_reg(RB_FFT_RESET, 1);
    set_write(SR_FFT_RESET, 0);
    read_reg(RB_FFT_RESET, 0);
    set_write(SR_FFT_SIZE_LOG2, 5);
    read_reg(RB_FFT_SIZE_LOG2, 5);
    set_write(SR_FFT_SIZE_LOG2, 1);
    read_reg(RB_FFT_SIZE_LOG2, 3);
    set_write(SR_FFT_SIZE_LOG2, 12);
    read_reg(RB_FFT_SIZE_LOG2, 8);
    set_write(SR_FFT_SHIFT_CONFIG, 2);
    read_reg(RB_FFT_SHIFT_CONFIG, 2);
    set_write(SR_OUT_MODE, 2);
    read_reg(RB_OUT_MODE, 2);
    // Unmapped addresses next to real ones
    set_write(8'd131, 32'h1);
    set_write(8'd128, 32'h5);
    read_reg(RB_FFT_RESET, 0);
    read_reg(RB_FFT_SIZE_LOG2, 8);
    read_reg(RB_FFT_SHIFT_CONFIG, 2);
    read_reg(RB_OUT_MODE, 2);
  endtask

  task automatic test_order(input shift_mode_t shift, input logic [SAMPLE_W-1:0] base,
                            input bit rand_ready);
    configure(4, shift, OUT_COMPLEX);
    fill_frame(16, base);
    expect_order(16, shift);
    send_bins(16, 16);
    collect_frame(16, rand_ready);
  endtask

  task automatic test_power();
    configure(4, SHIFT_NATURAL, OUT_MAG_SQ);
    for (int k = 0; k < 16; k++) begin
      frame_in[k] = $random(seed);
    end
    // Full-scale corners and a zero bin
    frame_in[0] = 32'h7FFF_7FFF;
    frame_in[1] = 32'h8000_8000;
    frame_in[2] = 32'h0000_0000;
    for (int k = 0; k < 16; k++) begin
      exp_q.push_back(power_word(frame_in[k]));
    end
    send_bins(16, 16);
    collect_frame(16, 1'b1);
    test_order(SHIFT_NATURAL, 16'h5000, 1'b0);
  endtask

  task automatic test_midframe_reset();
    // Partial frame latches size and order unlike the frame after it
    configure(5, SHIFT_REVERSE, OUT_COMPLEX);
    fill_frame(16, 16'h3000);
    send_bins(16, 5);
    set_write(SR_FFT_RESET, 1);
    set_write(SR_FFT_RESET, 0);
    check_flag(o_tvalid, 1'b0, "o_tvalid after block reset");
    check_flag(o_tready, 1'b1, "o_tready after block reset");
    test_order(SHIFT_CENTER, 16'h4000, 1'b0);
  endtask

  initial begin
    seed       = 32'h11d9_7687;
    word_errs  = 0;
    rb_errs    = 0;
    last_errs  = 0;
    flag_errs  = 0;
    other_errs = 0;
    i_rst_n    = 1'b0;
    i_set_stb  = 1'b0;
    i_set_addr = '0;
    i_set_data = '0;
    i_tdata    = '0;
    i_tuser    = '0;
    i_tlast    = 1'b0;
    i_tvalid   = 1'b0;
    i_tready   = 1'b0;
    repeat (16) @(negedge ce_clk);
    i_rst_n = 1'b1;
    @(negedge ce_clk);

    test_reset_state();
    test_reg_writes();
    test_order(SHIFT_CENTER, 16'h1000, 1'b0);
    test_order(SHIFT_NATURAL, 16'h2000, 1'b0);
    test_order(SHIFT_REVERSE, 16'h2800, 1'b1);
    test_power();
    test_midframe_reset();

    $display("Errors: data %0d, readback %0d, last %0d, flags %0d, other %0d",
             word_errs, rb_errs, last_errs, flag_errs, other_errs);
    if (word_errs + rb_errs + last_errs + flag_errs + other_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
src/spec_pkg.sv
src/axis_pipe_reg.sv
src/spec_settings.sv
src/bin_reorder.sv
src/power_path.sv
src/spec_post_top.sv
tb/spec_post_asserts.sv
tb/tb_spec_post.sv
